//--- verilog/upload_pkg.sv
`default_nettype none

package upload_pkg;

   parameter int DDR_ADDR_W = 28;
   parameter int RAM_ADDR_W = 27;
   parameter int PAGE_SHIFT = 14;   // 16 KB page
   parameter int HDR_BYTES  = 16;
   parameter int SLOTS      = 64;
   parameter int REFS       = 16;
   parameter int PAGES_W    = 11;
   parameter int LEN_W      = PAGES_W + PAGE_SHIFT;
   parameter int DESC_W     = 59;

   parameter logic [23:0] SIGNATURE = "MSX";

   // Descriptor field offsets
   parameter int D_SS    = 0;       // 4 bits
   parameter int D_KIND  = 4;       // 2 bits
   parameter int D_DEV   = 6;       // 8 bits
   parameter int D_MAP   = 14;      // 8 bits
   parameter int D_PAGES = 22;      // 11 bits
   parameter int D_MODE  = 33;      // 8 bits
   parameter int D_PARAM = 41;      // 8 bits
   parameter int D_PAY   = 49;      // bits 58:50 spare

   typedef enum logic [3:0] {REC_CONFIG = 4'd2, REC_SLOT_INTERNAL = 4'd3} record_t;

   typedef enum logic [1:0] {DATA_NONE, DATA_ROM, DATA_RAM} data_kind_t;

   typedef enum logic [7:0] {
      MAPPER_UNUSED = 8'd0,
      MAPPER_OFFSET,
      MAPPER_ASCII8,
      MAPPER_ASCII16,
      MAPPER_KONAMI,
      MAPPER_KONAMI_SCC
   } mapper_t;

   typedef enum logic [7:0] {DEVICE_NONE = 8'd0, DEVICE_FDC, DEVICE_SCC} device_t;

   typedef enum logic [1:0] {MSX1, MSX2, MSX2P, MSXTR} msx_type_t;

endpackage

`default_nettype wire

//--- verilog/sync_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module sync_fifo #(
   parameter int WIDTH = 8,
   parameter int DEPTH = 16
) (
   input  wire              clk,
   input  wire              rst,
   input  wire              flush,
   input  wire              push,
   input  wire [WIDTH-1:0]  wr_data,
   input  wire              pop,
   output logic [WIDTH-1:0] rd_data,
   output logic             full,
   output logic             empty
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   logic [WIDTH-1:0] mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W:0]   count;
   logic             do_push;
   logic             do_pop;

   assign do_push = push && !full;
   assign do_pop  = pop && !empty;
   assign full    = count == DEPTH;
   assign empty   = count == 0;
   assign rd_data = mem[rd_ptr];   // Fall-through read

   always_ff @(posedge clk) begin
      if (do_push) mem[wr_ptr] <= wr_data;
   end

   always_ff @(posedge clk) begin
      if (rst || flush) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (do_pop) rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: ;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- verilog/record_reader.sv
`timescale 1ns/1ns
`default_nettype none

module record_reader (
   input  wire                                clk,
   input  wire                                rst,
   input  wire                                ioctl_download,
   input  wire [15:0]                         ioctl_index,
   input  wire [26:0]                         ioctl_addr,
   output logic                               load,
   output logic                               busy,
   output logic [upload_pkg::DDR_ADDR_W-1:0]  ddr3_addr,
   output logic                               ddr3_rd,
   input  wire [7:0]                          ddr3_dout,
   input  wire                                ddr3_ready,
   output logic                               desc_push,
   output logic [upload_pkg::DESC_W-1:0]      desc_data,
   input  wire                                desc_full,
   output logic                               byte_push,
   output logic [7:0]                         byte_data,
   input  wire                                byte_full,
   output logic [3:0]                         slot_expander_en,
   output upload_pkg::msx_type_t              msx_type
);

   import upload_pkg::*;

   typedef enum logic [2:0] {IDLE, HEADER, CHECK, PAYLOAD, DONE} state_t;

   state_t             state;
   logic               dl_last;
   logic               dl_end;
   logic [26:0]        image_size;
   logic [7:0]         hdr [HDR_BYTES];
   logic [3:0]         hdr_cnt;
   logic               pending;
   logic               ready_q;
   logic               data_valid;
   logic [LEN_W-1:0]   pay_left;
   logic               sig_ok;
   record_t            rec_type;
   data_kind_t         kind;
   logic [PAGES_W-1:0] pages;

   assign dl_end     = dl_last && !ioctl_download && ioctl_index == 16'd1;
   assign data_valid = pending && ddr3_ready && !ready_q;   // Ready back after the gap
   assign sig_ok     = {hdr[0], hdr[1], hdr[2]} == SIGNATURE;
   assign rec_type   = record_t'(hdr[3][7:4]);
   assign kind       = (hdr[4][1:0] == 2'd3) ? DATA_NONE : data_kind_t'(hdr[4][1:0]);
   assign pages      = {hdr[5][2:0], hdr[6]};
   assign busy       = state inside {HEADER, CHECK, PAYLOAD};

   assign desc_push = state == CHECK && sig_ok && rec_type == REC_SLOT_INTERNAL && !desc_full;
   assign byte_push = state == PAYLOAD && data_valid;
   assign byte_data = ddr3_dout;

   always_comb begin
      desc_data                    = '0;
      desc_data[D_SS +: 4]         = hdr[3][3:0];
      desc_data[D_KIND +: 2]       = kind;
      desc_data[D_DEV +: 8]        = hdr[7];
      desc_data[D_MAP +: 8]        = hdr[8];
      desc_data[D_PAGES +: PAGES_W] = pages;
      desc_data[D_MODE +: 8]       = hdr[9];
      desc_data[D_PARAM +: 8]      = hdr[10];
      desc_data[D_PAY]             = kind == DATA_ROM;   // Bytes follow in payload FIFO
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         dl_last <= 1'b0;
         load    <= 1'b0;
      end else begin
         dl_last <= ioctl_download;
         load    <= dl_end;
      end
   end

   always_ff @(posedge clk) begin
      if (dl_end) image_size <= ioctl_addr;
   end

   always_ff @(posedge clk) begin
      if (state == HEADER && data_valid) hdr[hdr_cnt] <= ddr3_dout;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state            <= IDLE;
         ddr3_rd          <= 1'b0;
         ddr3_addr        <= '0;
         hdr_cnt          <= '0;
         pending          <= 1'b0;
         ready_q          <= 1'b0;
         pay_left         <= '0;
         slot_expander_en <= '0;
         msx_type         <= MSX1;
      end else begin
         ready_q <= ddr3_ready;
         if (load) begin
            state     <= HEADER;
            ddr3_rd   <= 1'b0;
            ddr3_addr <= '0;
            hdr_cnt   <= '0;
            pending   <= 1'b0;
         end else begin
            if (ddr3_rd && ddr3_ready) begin
               ddr3_rd   <= 1'b0;
               ddr3_addr <= ddr3_addr + 1'b1;
               pending   <= 1'b1;
            end
            if (data_valid) pending <= 1'b0;

            case (state)
               HEADER: begin
                  if (data_valid) begin
                     hdr_cnt <= hdr_cnt + 1'b1;
                     if (hdr_cnt == 4'(HDR_BYTES - 1)) state <= CHECK;
                  end else if (!ddr3_rd && !pending) begin
                     if (hdr_cnt == 4'd0 && ddr3_addr >= {1'b0, image_size}) begin
                        state <= DONE;   // End of image
                     end else if (!desc_full) begin
                        ddr3_rd <= 1'b1;
                     end
                  end
               end
               CHECK: begin
                  if (!sig_ok) begin
                     state <= DONE;
                  end else if (rec_type == REC_CONFIG) begin
                     slot_expander_en <= hdr[4][3:0];
                     msx_type         <= msx_type_t'(hdr[4][5:4]);
                     state            <= HEADER;
                  end else if (rec_type != REC_SLOT_INTERNAL) begin
                     state <= HEADER;   // Unknown type skipped
                  end else if (!desc_full) begin
                     pay_left <= LEN_W'(pages) << PAGE_SHIFT;
                     state    <= (kind == DATA_ROM && pages != '0) ? PAYLOAD : HEADER;
                  end
               end
               PAYLOAD: begin
                  if (data_valid) begin
                     pay_left <= pay_left - 1'b1;
                     if (pay_left == LEN_W'(1)) state <= HEADER;
                  end else if (!ddr3_rd && !pending && !byte_full) begin
                     ddr3_rd <= 1'b1;
                  end
               end
               DONE:    state <= IDLE;
               default: ;
            endcase
         end
      end
   end

endmodule

`default_nettype wire

//--- verilog/slot_loader.sv
`timescale 1ns/1ns
`default_nettype none

module slot_loader (
   input  wire                               clk,
   input  wire                               rst,
   input  wire                               load,
   input  wire [upload_pkg::DESC_W-1:0]      desc_data,
   input  wire                               desc_empty,
   output logic                              desc_pop,
   input  wire [7:0]                         byte_data,
   input  wire                               byte_empty,
   output logic                              byte_pop,
   output logic [upload_pkg::RAM_ADDR_W-1:0] ram_addr,
   output logic [7:0]                        ram_din,
   output logic                              ram_ce,
   input  wire                               sdram_ready,
   output logic                              tbl_we,
   output logic [5:0]                        tbl_index,
   output logic                              tbl_alias,
   output logic [1:0]                        tbl_alias_page,
   output upload_pkg::mapper_t               tbl_mapper,
   output upload_pkg::device_t               tbl_device,
   output logic [3:0]                        tbl_ref,
   output logic [1:0]                        tbl_offset,
   input  wire [3:0]                         lookup_index,
   output logic [upload_pkg::RAM_ADDR_W-1:0] lookup_addr,
   output logic [15:0]                       lookup_pages,
   output logic                              lookup_ro,
   output logic                              busy
);

   import upload_pkg::*;

   typedef enum logic [1:0] {IDLE, FILL, STORE} state_t;

   state_t                state;
   logic [3:0]            slot_sub;
   logic                  payload;
   device_t               device;
   mapper_t               mapper;
   logic [7:0]            mode;
   logic [7:0]            param;
   logic [LEN_W-1:0]      left;
   logic [1:0]            page;
   logic [3:0]            ref_cnt;
   logic                  has_data;
   logic [1:0]            page_mode;
   data_kind_t            d_kind;
   logic [PAGES_W-1:0]    d_pages;
   logic [RAM_ADDR_W-1:0] lk_addr [REFS];
   logic [15:0]           lk_pages [REFS];
   logic                  lk_ro [REFS];

   assign d_kind   = data_kind_t'(desc_data[D_KIND +: 2]);
   assign d_pages  = desc_data[D_PAGES +: PAGES_W];
   assign desc_pop = state == IDLE && !desc_empty;
   assign ram_ce   = state == FILL && sdram_ready && (!payload || !byte_empty);
   assign byte_pop = ram_ce && payload;
   assign ram_din  = payload ? byte_data : (ram_addr[8] == ram_addr[1]) ? 8'hFF : 8'h00;

   assign page_mode      = mode[{page, 1'b0} +: 2];
   assign tbl_we         = state == STORE && page_mode != 2'd0;
   assign tbl_index      = {slot_sub, page};
   assign tbl_alias      = page_mode == 2'd1;
   assign tbl_alias_page = param[{page, 1'b0} +: 2];
   assign tbl_offset     = param[{page, 1'b0} +: 2];
   assign tbl_mapper     = (page_mode == 2'd2) ? mapper : MAPPER_UNUSED;
   assign tbl_device     = device;   // Replaced by the table on alias
   assign tbl_ref        = ref_cnt;
   assign busy           = state != IDLE || !desc_empty;

   assign lookup_addr  = lk_addr[lookup_index];
   assign lookup_pages = lk_pages[lookup_index];
   assign lookup_ro    = lk_ro[lookup_index];

   always_ff @(posedge clk) begin
      if (desc_pop) begin
         slot_sub <= desc_data[D_SS +: 4];
         payload  <= desc_data[D_PAY];
         device   <= device_t'(desc_data[D_DEV +: 8]);
         mapper   <= mapper_t'(desc_data[D_MAP +: 8]);
         mode     <= desc_data[D_MODE +: 8];
         param    <= desc_data[D_PARAM +: 8];
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= IDLE;
         ram_addr <= '0;
         left     <= '0;
         page     <= '0;
         ref_cnt  <= '0;
         has_data <= 1'b0;
         for (int i = 0; i < REFS; i++) begin
            lk_addr[i]  <= '0;
            lk_pages[i] <= '0;
            lk_ro[i]    <= 1'b0;
         end
      end else if (load) begin
         state    <= IDLE;
         ram_addr <= '0;
         ref_cnt  <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (desc_pop) begin
                  left     <= LEN_W'(d_pages) << PAGE_SHIFT;
                  page     <= '0;
                  has_data <= d_kind != DATA_NONE;
                  if (d_kind != DATA_NONE) begin
                     lk_addr[ref_cnt]  <= ram_addr;
                     lk_pages[ref_cnt] <= 16'(d_pages);
                     lk_ro[ref_cnt]    <= d_kind == DATA_ROM;
                  end
                  state <= (d_kind != DATA_NONE && d_pages != '0) ? FILL : STORE;
               end
            end
            FILL: begin
               if (ram_ce) begin
                  ram_addr <= ram_addr + 1'b1;
                  left     <= left - 1'b1;
                  if (left == LEN_W'(1)) state <= STORE;
               end
            end
            STORE: begin
               page <= page + 1'b1;
               if (page == 2'd3) begin
                  ref_cnt <= ref_cnt + 4'(has_data);   // Next lookup entry
                  state   <= IDLE;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- verilog/slot_table.sv
`timescale 1ns/1ns
`default_nettype none

module slot_table (
   input  wire                  clk,
   input  wire                  rst,
   input  wire                  load,
   input  wire                  tbl_we,
   input  wire [5:0]            tbl_index,
   input  wire                  tbl_alias,
   input  wire [1:0]            tbl_alias_page,
   input  wire upload_pkg::mapper_t tbl_mapper,
   input  wire upload_pkg::device_t tbl_device,
   input  wire [3:0]            tbl_ref,
   input  wire [1:0]            tbl_offset,
   input  wire [5:0]            layout_index,
   output upload_pkg::mapper_t  layout_mapper,
   output upload_pkg::device_t  layout_device,
   output logic [3:0]           layout_ref,
   output logic [1:0]           layout_offset,
   output logic                 busy
);

   import upload_pkg::*;

   mapper_t    mapper_mem [SLOTS];
   device_t    device_mem [SLOTS];
   logic [3:0] ref_mem [SLOTS];
   logic [1:0] offset_mem [SLOTS];
   logic [5:0] clr_idx;
   logic [5:0] src;

   assign src = {tbl_index[5:2], tbl_alias_page};   // Same subslot, other page

   assign layout_mapper = mapper_mem[layout_index];
   assign layout_device = device_mem[layout_index];
   assign layout_ref    = ref_mem[layout_index];
   assign layout_offset = offset_mem[layout_index];

   always_ff @(posedge clk) begin
      if (rst) begin
         busy    <= 1'b0;
         clr_idx <= '0;
         for (int i = 0; i < SLOTS; i++) begin
            mapper_mem[i] <= MAPPER_UNUSED;
            device_mem[i] <= DEVICE_NONE;
            ref_mem[i]    <= '0;
            offset_mem[i] <= '0;
         end
      end else if (load) begin
         busy    <= 1'b1;
         clr_idx <= '0;
      end else begin
         if (busy) begin
            mapper_mem[clr_idx] <= MAPPER_UNUSED;
            device_mem[clr_idx] <= DEVICE_NONE;
            ref_mem[clr_idx]    <= '0;
            offset_mem[clr_idx] <= '0;
            clr_idx             <= clr_idx + 1'b1;
            if (clr_idx == 6'(SLOTS - 1)) busy <= 1'b0;
         end
         if (tbl_we) begin
            if (tbl_alias) begin
               mapper_mem[tbl_index] <= mapper_mem[src];
               device_mem[tbl_index] <= DEVICE_NONE;
               ref_mem[tbl_index]    <= ref_mem[src];
               offset_mem[tbl_index] <= offset_mem[src];
            end else begin
               mapper_mem[tbl_index] <= tbl_mapper;
               device_mem[tbl_index] <= tbl_device;
               ref_mem[tbl_index]    <= tbl_ref;
               offset_mem[tbl_index] <= tbl_offset;
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- verilog/memory_upload.sv
`timescale 1ns/1ns
`default_nettype none

module memory_upload #(
   parameter int DESC_DEPTH = 4,
   parameter int DATA_DEPTH = 16
) (
   input  wire                  clk,
   input  wire                  rst,
   input  wire                  ioctl_download,
   input  wire [15:0]           ioctl_index,
   input  wire [26:0]           ioctl_addr,
   output logic [27:0]          ddr3_addr,
   output logic                 ddr3_rd,
   input  wire [7:0]            ddr3_dout,
   input  wire                  ddr3_ready,
   output logic [26:0]          ram_addr,
   output logic [7:0]           ram_din,
   output logic                 ram_ce,
   input  wire                  sdram_ready,
   output logic                 reset_rq,
   output logic [3:0]           slot_expander_en,
   output upload_pkg::msx_type_t msx_type,
   input  wire [5:0]            layout_index,
   output upload_pkg::mapper_t  layout_mapper,
   output upload_pkg::device_t  layout_device,
   output logic [3:0]           layout_ref,
   output logic [1:0]           layout_offset,
   input  wire [3:0]            lookup_index,
   output logic [26:0]          lookup_addr,
   output logic [15:0]          lookup_pages,
   output logic                 lookup_ro
);

   import upload_pkg::*;

   logic              load;
   logic              reader_busy;
   logic              loader_busy;
   logic              table_busy;
   logic              desc_push;
   logic              desc_pop;
   logic              desc_full;
   logic              desc_empty;
   logic [DESC_W-1:0] desc_wr;
   logic [DESC_W-1:0] desc_rd;
   logic              byte_push;
   logic              byte_pop;
   logic              byte_full;
   logic              byte_empty;
   logic [7:0]        byte_wr;
   logic [7:0]        byte_rd;
   logic              tbl_we;
   logic [5:0]        tbl_index;
   logic              tbl_alias;
   logic [1:0]        tbl_alias_page;
   mapper_t           tbl_mapper;
   device_t           tbl_device;
   logic [3:0]        tbl_ref;
   logic [1:0]        tbl_offset;

   assign reset_rq = reader_busy | loader_busy | table_busy;

   record_reader u_reader (
      .clk(clk), .rst(rst),
      .ioctl_download(ioctl_download), .ioctl_index(ioctl_index), .ioctl_addr(ioctl_addr),
      .load(load), .busy(reader_busy),
      .ddr3_addr(ddr3_addr), .ddr3_rd(ddr3_rd), .ddr3_dout(ddr3_dout), .ddr3_ready(ddr3_ready),
      .desc_push(desc_push), .desc_data(desc_wr), .desc_full(desc_full),
      .byte_push(byte_push), .byte_data(byte_wr), .byte_full(byte_full),
      .slot_expander_en(slot_expander_en), .msx_type(msx_type)
   );

   sync_fifo #(.WIDTH(DESC_W), .DEPTH(DESC_DEPTH)) u_desc_fifo (
      .clk(clk), .rst(rst), .flush(load),
      .push(desc_push), .wr_data(desc_wr), .pop(desc_pop),
      .rd_data(desc_rd), .full(desc_full), .empty(desc_empty)
   );

   sync_fifo #(.WIDTH(8), .DEPTH(DATA_DEPTH)) u_byte_fifo (
      .clk(clk), .rst(rst), .flush(load),
      .push(byte_push), .wr_data(byte_wr), .pop(byte_pop),
      .rd_data(byte_rd), .full(byte_full), .empty(byte_empty)
   );

   slot_loader u_loader (
      .clk(clk), .rst(rst), .load(load),
      .desc_data(desc_rd), .desc_empty(desc_empty), .desc_pop(desc_pop),
      .byte_data(byte_rd), .byte_empty(byte_empty), .byte_pop(byte_pop),
      .ram_addr(ram_addr), .ram_din(ram_din), .ram_ce(ram_ce), .sdram_ready(sdram_ready),
      .tbl_we(tbl_we), .tbl_index(tbl_index), .tbl_alias(tbl_alias),
      .tbl_alias_page(tbl_alias_page), .tbl_mapper(tbl_mapper), .tbl_device(tbl_device),
      .tbl_ref(tbl_ref), .tbl_offset(tbl_offset),
      .lookup_index(lookup_index), .lookup_addr(lookup_addr),
      .lookup_pages(lookup_pages), .lookup_ro(lookup_ro),
      .busy(loader_busy)
   );

   slot_table u_table (
      .clk(clk), .rst(rst), .load(load),
      .tbl_we(tbl_we), .tbl_index(tbl_index), .tbl_alias(tbl_alias),
      .tbl_alias_page(tbl_alias_page), .tbl_mapper(tbl_mapper), .tbl_device(tbl_device),
      .tbl_ref(tbl_ref), .tbl_offset(tbl_offset),
      .layout_index(layout_index), .layout_mapper(layout_mapper),
      .layout_device(layout_device), .layout_ref(layout_ref), .layout_offset(layout_offset),
      .busy(table_busy)
   );

endmodule

`default_nettype wire

//--- verif/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
   parameter int PERIOD = 4
) (
   output logic clk
);

   initial clk = 1'b0;
   always #(PERIOD / 2) clk = ~clk;

endmodule

`default_nettype wire

//--- verif/memory_upload_tb.sv
`timescale 1ns/1ns
`default_nettype none

module memory_upload_tb;

   import upload_pkg::*;

   localparam int PAGE_BYTES      = 16384;
   localparam int ROM_BASE        = 16;
   localparam int ROM_DATA        = ROM_BASE + 16;
   localparam int RAM_BASE        = ROM_DATA + PAGE_BYTES;
   localparam int BAD_BASE        = RAM_BASE + 16;
   localparam int IMAGE_SIZE      = BAD_BASE + 16;
   localparam int WATCHDOG_CYCLES = 4 * (PAGE_BYTES + 5 * 16) * 8 + 2000;

   localparam logic [3:0] CFG_EXP   = 4'hA;
   localparam logic [1:0] CFG_TYPE  = 2'd2;
   localparam logic [3:0] ROM_SS    = 4'd5;
   localparam logic [7:0] ROM_DEV   = 8'd2;
   localparam logic [7:0] ROM_MAP   = 8'd4;
   localparam logic [7:0] ROM_MODE  = 8'h1A;   // Mode 2 on pages 0 and 1, alias on page 2
   localparam logic [7:0] ROM_PARAM = 8'h06;   // Offsets 2 and 1, page 2 aliases page 0
   localparam logic [3:0] RAM_SS    = 4'd3;
   localparam logic [7:0] RAM_DEV   = 8'd1;
   localparam logic [7:0] RAM_MAP   = 8'd3;    // Dropped by mode 3
   localparam logic [7:0] RAM_PARAM = 8'hE4;

   logic        clk;
   logic        rst;
   logic        ioctl_download;
   logic [15:0] ioctl_index;
   logic [26:0] ioctl_addr;
   logic [27:0] ddr3_addr;
   logic        ddr3_rd;
   logic [7:0]  ddr3_dout;
   logic        ddr3_ready;
   logic [26:0] ram_addr;
   logic [7:0]  ram_din;
   logic        ram_ce;
   logic        sdram_ready;
   logic        reset_rq;
   logic [3:0]  slot_expander_en;
   msx_type_t   msx_type;
   logic [5:0]  layout_index;
   mapper_t     layout_mapper;
   device_t     layout_device;
   logic [3:0]  layout_ref;
   logic [1:0]  layout_offset;
   logic [3:0]  lookup_index;
   logic [26:0] lookup_addr;
   logic [15:0] lookup_pages;
   logic        lookup_ro;

   logic [7:0]  ddr_mem [IMAGE_SIZE];
   logic [7:0]  ram_mem [2 * PAGE_BYTES];
   integer      seed = 82173;
   int          gap;
   logic        accept_next;
   logic [27:0] read_addr;

   tb_clock u_clock (.clk(clk));

   memory_upload #(.DESC_DEPTH(4), .DATA_DEPTH(16)) i_dut (
      .clk(clk), .rst(rst),
      .ioctl_download(ioctl_download), .ioctl_index(ioctl_index), .ioctl_addr(ioctl_addr),
      .ddr3_addr(ddr3_addr), .ddr3_rd(ddr3_rd), .ddr3_dout(ddr3_dout), .ddr3_ready(ddr3_ready),
      .ram_addr(ram_addr), .ram_din(ram_din), .ram_ce(ram_ce), .sdram_ready(sdram_ready),
      .reset_rq(reset_rq), .slot_expander_en(slot_expander_en), .msx_type(msx_type),
      .layout_index(layout_index), .layout_mapper(layout_mapper),
      .layout_device(layout_device), .layout_ref(layout_ref), .layout_offset(layout_offset),
      .lookup_index(lookup_index), .lookup_addr(lookup_addr),
      .lookup_pages(lookup_pages), .lookup_ro(lookup_ro)
   );

   function automatic logic [7:0] rom_byte(input int k);
      return 8'(k ^ (k >> 6) ^ (k >> 11) ^ 8'h5A);
   endfunction

   function automatic logic [7:0] stripe_byte(input int a);
      return (a[8] == a[1]) ? 8'hFF : 8'h00;
   endfunction

   task automatic report_failure(input string what);
      $display("sim failed");
      $display("%s", what);
      $fatal(1, "stopping at the first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (actual === expected)
      else begin
         $display("sim failed");
         $display("mismatch %s expected %0h actual %0h", name, expected, actual);
         $fatal(1, "stopping at the first error");
      end
   endtask

   task automatic write_header(input int base, input logic [23:0] sig, input logic [3:0] rtype,
                               input logic [3:0] ss, input logic [7:0] b4,
                               input logic [7:0] dev, input logic [7:0] mapper,
                               input logic [7:0] mode, input logic [7:0] param);
      ddr_mem[base]      = sig[23:16];
      ddr_mem[base + 1]  = sig[15:8];
      ddr_mem[base + 2]  = sig[7:0];
      ddr_mem[base + 3]  = {rtype, ss};
      ddr_mem[base + 4]  = b4;
      ddr_mem[base + 5]  = 8'h00;   // One page
      ddr_mem[base + 6]  = 8'h01;
      ddr_mem[base + 7]  = dev;
      ddr_mem[base + 8]  = mapper;
      ddr_mem[base + 9]  = mode;
      ddr_mem[base + 10] = param;
      for (int i = 11; i < 16; i++) ddr_mem[base + i] = 8'h00;
   endtask

   task automatic wait_for_reset_rq(input logic level, input int limit, input string what);
      int n;
      n = 0;
      while (reset_rq !== level && n < limit) begin
         @(negedge clk);
         n++;
      end
      assert (reset_rq === level) else report_failure(what);
   endtask

   task automatic run_download(input int size);
      ioctl_download = 1'b1;
      ioctl_index    = 16'd1;
      repeat (3) @(negedge clk);
      ioctl_addr = 27'(size);
      @(negedge clk);
      ioctl_download = 1'b0;
      wait_for_reset_rq(1'b1, 8, "reset_rq did not rise after the download");
      wait_for_reset_rq(1'b0, WATCHDOG_CYCLES, "reset_rq did not fall after the upload");
   endtask

   task automatic check_layout(input string tag, input logic loaded);
      int         p;
      logic [7:0] e_map;
      logic [7:0] e_dev;
      logic [3:0] e_ref;
      logic [1:0] e_off;
      for (int i = 0; i < SLOTS; i++) begin
         p     = i % 4;
         e_map = MAPPER_UNUSED;
         e_dev = DEVICE_NONE;
         e_ref = 4'd0;
         e_off = 2'd0;
         if (loaded && i / 4 == ROM_SS && p < 2) begin
            e_map = ROM_MAP;
            e_dev = ROM_DEV;
            e_off = ROM_PARAM[2 * p +: 2];
         end else if (loaded && i / 4 == ROM_SS && p == 2) begin
            e_map = ROM_MAP;   // Copy of page 0
            e_off = ROM_PARAM[1:0];
         end else if (loaded && i / 4 == RAM_SS) begin
            e_dev = RAM_DEV;
            e_ref = 4'd1;
            e_off = RAM_PARAM[2 * p +: 2];
         end
         @(negedge clk) layout_index = 6'(i);
         @(posedge clk);
         check_value($sformatf("%s layout %0d mapper", tag, i), e_map, layout_mapper);
         check_value($sformatf("%s layout %0d device", tag, i), e_dev, layout_device);
         check_value($sformatf("%s layout %0d ref", tag, i), e_ref, layout_ref);
         check_value($sformatf("%s layout %0d offset", tag, i), e_off, layout_offset);
      end
   endtask

   // DDR3 model drops ready for 1 to 3 cycles after each accepted read
   always @(negedge clk) begin
      sdram_ready = $random(seed) & 1;
      if (accept_next) begin
         ddr3_ready  = 1'b0;
         gap         = 1 + {$random(seed)} % 3;
         accept_next = 1'b0;
      end else if (gap != 0) begin
         gap = gap - 1;
         if (gap == 0) begin
            ddr3_ready = 1'b1;
            ddr3_dout  = (read_addr < IMAGE_SIZE) ? ddr_mem[read_addr] : 8'h00;
         end
      end
      if (ddr3_ready && ddr3_rd) begin
         accept_next = 1'b1;   // Taken on the next rising edge
         read_addr   = ddr3_addr;
      end
   end

   always @(posedge clk) begin
      assert (!ram_ce || sdram_ready) else report_failure("ram_ce high while sdram_ready low");
      if (ram_ce) begin
         assert (ram_addr < 2 * PAGE_BYTES) else report_failure("RAM write past the two pages");
         ram_mem[ram_addr[14:0]] = ram_din;
      end
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      report_failure("watchdog expired before the upload finished");
   end

   initial begin
      int lk0;
      rst            = 1'b1;
      ioctl_download = 1'b0;
      ioctl_index    = 16'd0;
      ioctl_addr     = '0;
      ddr3_dout      = 8'h00;
      ddr3_ready     = 1'b1;
      sdram_ready    = 1'b0;
      layout_index   = '0;
      lookup_index   = '0;
      accept_next    = 1'b0;
      gap            = 0;
      read_addr      = '0;

      write_header(0, "MSX", 4'd2, 4'd0, {2'b00, CFG_TYPE, CFG_EXP}, 8'd0, 8'd0, 8'd0, 8'd0);
      write_header(ROM_BASE, "MSX", 4'd3, ROM_SS, 8'h01, ROM_DEV, ROM_MAP, ROM_MODE, ROM_PARAM);
      for (int k = 0; k < PAGE_BYTES; k++) ddr_mem[ROM_DATA + k] = rom_byte(k);
      write_header(RAM_BASE, "MSX", 4'd3, RAM_SS, 8'h02, RAM_DEV, RAM_MAP, 8'hFF, RAM_PARAM);
      write_header(BAD_BASE, "MSY", 4'd3, 4'd7, 8'h01, 8'd1, 8'd1, 8'hAA, 8'h00);

      repeat (4) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      check_value("reset_rq after reset", 0, reset_rq);
      check_value("ram_ce after reset", 0, ram_ce);
      check_value("ddr3_rd after reset", 0, ddr3_rd);

      run_download(IMAGE_SIZE);

      check_value("slot_expander_en", CFG_EXP, slot_expander_en);
      check_value("msx_type", CFG_TYPE, msx_type);

      @(negedge clk) lookup_index = 4'd0;
      @(posedge clk);
      lk0 = lookup_addr;
      check_value("lookup 0 pages", 1, lookup_pages);
      check_value("lookup 0 ro", 1, lookup_ro);
      for (int k = 0; k < PAGE_BYTES; k++)
         check_value($sformatf("rom byte %0d", k), rom_byte(k), ram_mem[lk0 + k]);

      @(negedge clk) lookup_index = 4'd1;
      @(posedge clk);
      check_value("lookup 1 addr", lk0 + PAGE_BYTES, lookup_addr);
      check_value("lookup 1 pages", 1, lookup_pages);
      check_value("lookup 1 ro", 0, lookup_ro);
      for (int a = lookup_addr; a < lookup_addr + PAGE_BYTES; a++)
         check_value($sformatf("stripe byte %0d", a), stripe_byte(a), ram_mem[a]);

      // Bad signature must leave the third entry as reset
      @(negedge clk) lookup_index = 4'd2;
      @(posedge clk);
      check_value("lookup 2 pages", 0, lookup_pages);
      check_value("lookup 2 addr", 0, lookup_addr);

      check_layout("full image", 1'b1);

      repeat (16) begin
         @(negedge clk);
         assert (!reset_rq && !ddr3_rd)
         else report_failure("upload went on after the bad record");
      end

      run_download(ROM_BASE);   // Image ends after the CONFIG record
      check_layout("config only", 1'b0);

      $display("sim passed");
      $finish;
   end

endmodule

`default_nettype wire

//--- sim.f
verilog/upload_pkg.sv
verilog/sync_fifo.sv
verilog/record_reader.sv
verilog/slot_loader.sv
verilog/slot_table.sv
verilog/memory_upload.sv
verif/tb_clock.sv
verif/memory_upload_tb.sv

//--- Bender.yml
package:
  name: memory_upload

sources:
  - verilog/upload_pkg.sv
  - verilog/sync_fifo.sv
  - verilog/record_reader.sv
  - verilog/slot_loader.sv
  - verilog/slot_table.sv
  - verilog/memory_upload.sv
  - target: simulation
    files:
      - verif/tb_clock.sv
      - verif/memory_upload_tb.sv
